// ==== flist.f ====
verilog/i2c_pkg.sv
verilog/i2c_control_unit.sv
verilog/i2c_timebase.sv
verilog/i2c_bit_engine.sv
verilog/i2c_master_top.sv
test/i2c_target_model.sv
test/i2c_master_tb.sv

// ==== test/i2c_master_tb.sv ====
// I2C write master testbench: register file, transfers, bit rate and bus back-pressure
module i2c_master_tb import i2c_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    logic       clock;
    logic       reset;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;
    i2c_pins_t  pins;
    logic       sda_line;
    logic       model_sda_low;
    logic [6:0] target_address;
    logic       bus_taken;
    logic       ack_prev;
    integer     seed;

    i2c_master_top DUT (
        .clock    (clock),
        .reset    (reset),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .pins     (pins),
        .sda_line (sda_line)
    );

    i2c_target_model target (
        .scl_low     (pins.scl_low),
        .sda_line    (sda_line),
        .own_address (target_address),
        .sda_low     (model_sda_low)
    );

    // Open-drain wired-AND of both drivers
    assign sda_line = !(pins.sda_low || model_sda_low);

    initial clock = 1'b0;
    always #2 clock = ~clock;

    task automatic stop_failed();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERR at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
            stop_failed();
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond === 1'b1) else begin
            $display("At %0t: %s", $time, msg);
            stop_failed();
        end
    endtask

    // ack must drop again after one cycle
    always @(posedge clock) begin
        if (reset === 1'b1) begin
            check_true(!(ack_prev && wb_rsp.ack), "Wishbone ack stayed high for two cycles");
        end
        ack_prev <= wb_rsp.ack;
    end

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    // Edges are counted from the call, so time spent waiting for the bus is included
    task automatic wb_access(input logic we, input logic [7:0] adr, input logic [31:0] data,
                             output logic [31:0] rdata, output int edges);
        edges = 0;
        while (bus_taken) begin
            next_cycle();
            edges++;
            check_true(edges < 4000, "Wishbone bus never became free");
        end
        bus_taken    = 1'b1;
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = we;
        wb_req.adr   = adr;
        wb_req.dat_w = data;
        do begin
            next_cycle();
            edges++;
            check_true(edges < 4000, "Wishbone access was never acknowledged");
        end while (!wb_rsp.ack);
        rdata     = wb_rsp.dat_r;
        wb_req    = '0;
        // One idle cycle with stb low before the bus is free again
        next_cycle();
        bus_taken = 1'b0;
    endtask

    task automatic wb_write(input logic [7:0] adr, input logic [31:0] data, output int edges);
        logic [31:0] unused;
        wb_access(1'b1, adr, data, unused, edges);
    endtask

    task automatic wb_read(input logic [7:0] adr, output logic [31:0] data, output int edges);
        wb_access(1'b0, adr, '0, data, edges);
    endtask

    task automatic write_plain(input logic [7:0] adr, input logic [31:0] data);
        int edges;
        wb_write(adr, data, edges);
        check_value("write ack edges", 2, edges);
    endtask

    task automatic read_check(input logic [7:0] adr, input logic [31:0] expected,
                              input string name);
        logic [31:0] data;
        int          edges;
        wb_read(adr, data, edges);
        check_value("read ack edges", 2, edges);
        check_value(name, expected, data);
    endtask

    task automatic readback_random(input logic [7:0] adr, input logic [31:0] mask,
                                   input string name);
        logic [31:0] value;
        value = $random(seed);
        write_plain(adr, value);
        read_check(adr, value & mask, name);
    endtask

    // START or AUTO_WRITE; ack may only come once STOP is on the lines
    task automatic run_transfer(input logic [7:0] adr, input logic [31:0] data);
        int starts;
        int stops;
        int edges;
        starts = target.start_count;
        stops  = target.stop_count;
        target.received.delete();
        wb_write(adr, data, edges);
        check_value("target start count", starts + 1, target.start_count);
        check_value("target stop count", stops + 1, target.stop_count);
    endtask

    task automatic check_received(input int count, input logic [7:0] b0,
                                  input logic [7:0] b1, input logic [7:0] b2);
        logic [7:0] expected[3];
        int         i;
        expected = '{b0, b1, b2};
        check_value("received byte count", count, target.received.size());
        for (i = 0; i < count; i++) begin
            check_value($sformatf("received byte %0d", i), expected[i], target.received[i]);
        end
    endtask

    task automatic measure_scl_high(output int cycles);
        int waited;
        waited = 0;
        while (!pins.scl_low) begin
            next_cycle();
            waited++;
            check_true(waited < 4000, "SCL was never pulled low");
        end
        while (pins.scl_low) begin
            next_cycle();
            waited++;
            check_true(waited < 4000, "SCL was never released");
        end
        cycles = 0;
        while (!pins.scl_low) begin
            next_cycle();
            cycles++;
            check_true(cycles < 4000, "SCL stayed high");
        end
    endtask

    initial begin
        logic [6:0]  tgt;
        logic [7:0]  idx;
        logic [7:0]  dat;
        logic [31:0] word;
        logic [31:0] rdata;
        int          edges;
        int          high_cycles;
        int          stops;
        int          waited;
        int          p;
        seed           = 61090;
        reset          = 1'b0;
        wb_req         = '0;
        bus_taken      = 1'b0;
        target_address = 7'h50;
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b1;

        // Reset state
        check_value("pins", 0, pins);
        read_check(STATUS_OFFSET, 0, "status");
        read_check(PRESCALE_OFFSET, 1, "prescale");

        repeat (4) begin
            readback_random(CONTROL_OFFSET, 32'h0000_017F, "control");
            readback_random(REGISTER_OFFSET, 32'h0000_00FF, "register");
            readback_random(DATA_OFFSET, 32'h0000_00FF, "data");
            readback_random(PRESCALE_OFFSET, 32'h0000_FFFF, "prescale");
        end

        // Register path
        tgt            = $random(seed);
        idx            = $random(seed);
        dat            = $random(seed);
        target_address = tgt;
        write_plain(PRESCALE_OFFSET, 1);
        write_plain(CONTROL_OFFSET, {23'd0, 1'b1, 1'b0, tgt});
        write_plain(REGISTER_OFFSET, idx);
        write_plain(DATA_OFFSET, dat);
        run_transfer(START_OFFSET, 0);
        check_received(3, {tgt, 1'b0}, idx, dat);
        read_check(STATUS_OFFSET, 0, "status");

        // AUTO_WRITE with the timebase enable cleared
        write_plain(CONTROL_OFFSET, {25'd0, tgt});
        tgt            = $random(seed);
        idx            = $random(seed);
        dat            = $random(seed);
        word           = {8'd0, dat, idx, 1'b0, tgt};
        target_address = tgt;
        run_transfer(AUTO_WRITE_OFFSET, word);
        check_received(3, {tgt, 1'b0}, idx, dat);
        read_check(CONTROL_OFFSET, {25'd0, tgt}, "control");
        read_check(STATUS_OFFSET, 0, "status");

        // Refused address, then a matching transfer clears the flag
        target_address = tgt ^ 7'h01;
        run_transfer(AUTO_WRITE_OFFSET, word);
        check_received(1, {tgt, 1'b0}, 8'd0, 8'd0);
        read_check(STATUS_OFFSET, 2, "status");
        target_address = tgt;
        run_transfer(AUTO_WRITE_OFFSET, word);
        check_received(3, {tgt, 1'b0}, idx, dat);
        read_check(STATUS_OFFSET, 0, "status");

        // SCL high time is two quarters
        for (p = 1; p <= 5; p += 4) begin
            write_plain(PRESCALE_OFFSET, p);
            write_plain(CONTROL_OFFSET, {23'd0, 1'b1, 1'b0, tgt});
            fork
                run_transfer(START_OFFSET, 0);
                measure_scl_high(high_cycles);
            join
            check_value("scl high cycles", 2 * (p + 1), high_cycles);
        end

        // STATUS read queued behind a running transfer
        stops = target.stop_count;
        fork
            run_transfer(START_OFFSET, 0);
            begin
                waited = 0;
                do begin
                    next_cycle();
                    waited++;
                    check_true(waited < 4000, "transfer never reached its first byte");
                end while (target.received.size() == 0);
                check_true(target.stop_count == stops, "transfer ended before the read");
                wb_read(STATUS_OFFSET, rdata, edges);
                check_true(target.stop_count == stops + 1, "read acknowledged during transfer");
                check_true(edges > 2, "read was not held back by the transfer");
                check_value("status", 0, rdata);
            end
        join
        check_received(3, {tgt, 1'b0}, idx, dat);

        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== test/i2c_target_model.sv ====
// I2C target model: receives write frames, acknowledges its own address and logs every byte
module i2c_target_model (
    input  logic       scl_low,
    input  logic       sda_line,
    input  logic [6:0] own_address,
    output logic       sda_low
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] received[$];
    int         start_count;
    int         stop_count;

    logic       scl;
    logic       in_frame;
    logic       selected;
    logic       ack_pending;
    logic [7:0] shift_in;
    int         bit_count;
    int         byte_count;

    assign scl = !scl_low;

    initial begin
        sda_low     = 1'b0;
        start_count = 0;
        stop_count  = 0;
        in_frame    = 1'b0;
        selected    = 1'b0;
        ack_pending = 1'b0;
        shift_in    = '0;
        bit_count   = 0;
        byte_count  = 0;
    end

    // START: SDA falls while SCL is high
    always @(negedge sda_line) begin
        if (scl === 1'b1) begin
            start_count++;
            in_frame    = 1'b1;
            selected    = 1'b0;
            ack_pending = 1'b0;
            bit_count   = 0;
            byte_count  = 0;
        end
    end

    // STOP: SDA rises while SCL is high
    always @(posedge sda_line) begin
        if (scl === 1'b1 && in_frame) begin
            stop_count++;
            in_frame = 1'b0;
        end
    end

    // Data is valid while SCL is high, the ninth clock is the acknowledge
    always @(posedge scl) begin
        if (in_frame) begin
            if (bit_count == 8) begin
                bit_count = 0;
            end else begin
                shift_in = {shift_in[6:0], sda_line};
                bit_count++;
                if (bit_count == 8) begin
                    received.push_back(shift_in);
                    if (byte_count == 0) begin
                        selected = (shift_in[7:1] == own_address) && !shift_in[0];
                    end
                    byte_count++;
                    ack_pending = selected;
                end
            end
        end
    end

    // Pull SDA for the whole acknowledge clock, release on every other falling edge
    always @(negedge scl) begin
        sda_low     = ack_pending;
        ack_pending = 1'b0;
    end

endmodule

// ==== verilog/i2c_master_top.sv ====
// I2C write master top level: Wishbone control unit, prescaler and bit engine
module i2c_master_top import i2c_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  wb_req_t   wb_req,
    output wb_rsp_t   wb_rsp,
    output i2c_pins_t pins,
    input  logic      sda_line
);

    i2c_cmd_t    cmd;
    logic        start;
    logic        done;
    logic        nack;
    logic        tick_enable;
    logic [15:0] prescale;
    logic        tick;

    i2c_control_unit control_unit (
        .clock       (clock),
        .reset       (reset),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .done        (done),
        .nack        (nack),
        .cmd         (cmd),
        .start       (start),
        .tick_enable (tick_enable),
        .prescale    (prescale)
    );

    i2c_timebase timebase (
        .clock       (clock),
        .reset       (reset),
        .tick_enable (tick_enable),
        .prescale    (prescale),
        .tick        (tick)
    );

    i2c_bit_engine bit_engine (
        .clock    (clock),
        .reset    (reset),
        .start    (start),
        .cmd      (cmd),
        .tick     (tick),
        .sda_line (sda_line),
        .pins     (pins),
        .done     (done),
        .nack     (nack)
    );

endmodule

// ==== verilog/i2c_bit_engine.sv ====
// I2C bit engine: serializes START, three acknowledged bytes and STOP on open-drain lines
module i2c_bit_engine import i2c_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      start,
    input  i2c_cmd_t  cmd,
    input  logic      tick,
    input  logic      sda_line,
    output i2c_pins_t pins,
    output logic      done,
    output logic      nack
);

    eng_state_t state;
    quarter_t   quarter;

    logic [23:0] shift;
    logic [2:0]  bit_cnt;
    logic [1:0]  byte_cnt;
    logic        ack_sample;
    logic        sda_want;
    logic        sda_low_q;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state    <= ENG_IDLE;
            quarter  <= '0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
            done     <= 1'b0;
            nack     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ENG_IDLE: begin
                    if (start) begin
                        state    <= ENG_START_COND;
                        quarter  <= '0;
                        bit_cnt  <= '0;
                        byte_cnt <= '0;
                        nack     <= 1'b0;
                    end
                end
                ENG_START_COND: begin
                    if (tick) begin
                        quarter <= quarter + 2'd1;
                        if (quarter == 2'd3) begin
                            state <= ENG_SEND_BIT;
                        end
                    end
                end
                ENG_SEND_BIT: begin
                    if (tick) begin
                        quarter <= quarter + 2'd1;
                        if (quarter == 2'd3) begin
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7) begin
                                state <= ENG_ACK_BIT;
                            end
                        end
                    end
                end
                ENG_ACK_BIT: begin
                    if (tick) begin
                        quarter <= quarter + 2'd1;
                        if (quarter == 2'd3) begin
                            if (ack_sample) begin
                                // Refused byte ends the frame early
                                nack  <= 1'b1;
                                state <= ENG_STOP_COND;
                            end else if (byte_cnt == 2'd2) begin
                                state <= ENG_STOP_COND;
                            end else begin
                                byte_cnt <= byte_cnt + 2'd1;
                                state    <= ENG_SEND_BIT;
                            end
                        end
                    end
                end
                ENG_STOP_COND: begin
                    if (tick) begin
                        quarter <= quarter + 2'd1;
                        if (quarter == 2'd3) begin
                            state <= ENG_IDLE;
                            done  <= 1'b1;
                        end
                    end
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

    // Address byte carries R/W clear in its LSB
    always_ff @(posedge clock) begin
        if (state == ENG_IDLE && start) begin
            shift <= {cmd.target, 1'b0, cmd.index, cmd.data};
        end else if (state == ENG_SEND_BIT && tick && quarter == 2'd3) begin
            shift <= {shift[22:0], 1'b0};
        end
    end

    // Target response taken as SCL is about to rise
    always_ff @(posedge clock) begin
        if (state == ENG_ACK_BIT && tick && quarter == 2'd1) begin
            ack_sample <= sda_line;
        end
    end

    always_comb begin
        case (state)
            ENG_START_COND: sda_want = quarter[1];
            ENG_SEND_BIT:   sda_want = !shift[23];
            ENG_STOP_COND:  sda_want = (quarter != 2'd3);
            default:        sda_want = 1'b0;
        endcase
    end

    // SDA follows one clock behind, so it never moves on the SCL edge itself
    always_ff @(posedge clock) begin
        if (!reset) begin
            sda_low_q <= 1'b0;
        end else begin
            sda_low_q <= sda_want;
        end
    end

    // SCL low in the first half of every data, ACK and STOP bit
    assign pins.scl_low = (state == ENG_SEND_BIT || state == ENG_ACK_BIT ||
                           state == ENG_STOP_COND) && !quarter[1];
    assign pins.sda_low = sda_low_q;

endmodule

// ==== verilog/i2c_timebase.sv ====
// I2C timebase: programmable prescaler giving one quarter-bit tick per prescale+1 clocks
module i2c_timebase (
    input  logic        clock,
    input  logic        reset,
    input  logic        tick_enable,
    input  logic [15:0] prescale,
    output logic        tick
);

    logic [15:0] count;

    // Count runs 0, prescale, ..., 1 and ticks on the step back to zero
    always_ff @(posedge clock) begin
        if (!reset) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (!tick_enable) begin
            count <= '0;
            tick  <= 1'b0;
        end else begin
            if (count == 16'd0) begin
                count <= prescale;
            end else begin
                count <= count - 16'd1;
            end
            // A zero prescale ticks every clock
            tick <= (count == 16'd1) || (prescale == 16'd0);
        end
    end

endmodule

// ==== verilog/i2c_control_unit.sv ====
// I2C control unit: Wishbone register file that launches transfers and holds ack until done
module i2c_control_unit import i2c_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  wb_req_t     wb_req,
    output wb_rsp_t     wb_rsp,
    input  logic        done,
    input  logic        nack,
    output i2c_cmd_t    cmd,
    output logic        start,
    output logic        tick_enable,
    output logic [15:0] prescale
);

    cu_state_t state;
    wb_req_t   req_q;

    logic        ack_q;
    logic [31:0] dat_r_q;
    logic [31:0] read_mux;
    logic        request;

    logic        busy;
    logic        nack_flag;
    logic        auto_active;

    logic [6:0]  target_q;
    logic        enable_q;
    logic [7:0]  index_q;
    logic [7:0]  data_q;
    logic [15:0] prescale_q;

    // Ignore the request still held in the cycle where ack is high
    assign request = wb_req.cyc && wb_req.stb && !ack_q;

    // Latched request, sampled once per bus cycle
    always_ff @(posedge clock) begin
        if (state == CU_IDLE && request) begin
            req_q <= wb_req;
        end
    end

    always_comb begin
        case (req_q.adr)
            STATUS_OFFSET:   read_mux = {30'd0, nack_flag, busy};
            CONTROL_OFFSET:  read_mux = {23'd0, enable_q, 1'b0, target_q};
            REGISTER_OFFSET: read_mux = {24'd0, index_q};
            DATA_OFFSET:     read_mux = {24'd0, data_q};
            PRESCALE_OFFSET: read_mux = {16'd0, prescale_q};
            default:         read_mux = '0;
        endcase
    end

    // Read data is presented together with ack
    always_ff @(posedge clock) begin
        if (state == CU_REG_WRITE && !req_q.we) begin
            dat_r_q <= read_mux;
        end else begin
            dat_r_q <= '0;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state       <= CU_IDLE;
            ack_q       <= 1'b0;
            start       <= 1'b0;
            busy        <= 1'b0;
            nack_flag   <= 1'b0;
            auto_active <= 1'b0;
            target_q    <= '0;
            enable_q    <= 1'b0;
            index_q     <= '0;
            data_q      <= '0;
            prescale_q  <= 16'd1;
        end else begin
            ack_q <= 1'b0;
            start <= 1'b0;
            case (state)
                CU_IDLE: begin
                    if (request) begin
                        if (wb_req.we && (wb_req.adr == START_OFFSET ||
                                          wb_req.adr == AUTO_WRITE_OFFSET)) begin
                            state <= CU_XFER_LAUNCH;
                        end else begin
                            state <= CU_REG_WRITE;
                        end
                    end
                end
                CU_REG_WRITE: begin
                    if (req_q.we) begin
                        case (req_q.adr)
                            CONTROL_OFFSET: begin
                                target_q <= req_q.dat_w[6:0];
                                enable_q <= req_q.dat_w[8];
                            end
                            REGISTER_OFFSET: index_q    <= req_q.dat_w[7:0];
                            DATA_OFFSET:     data_q     <= req_q.dat_w[7:0];
                            PRESCALE_OFFSET: prescale_q <= req_q.dat_w[15:0];
                            default: ;
                        endcase
                    end
                    ack_q <= 1'b1;
                    state <= CU_IDLE;
                end
                CU_XFER_LAUNCH: begin
                    // Packed fields land in the same registers as the plain path
                    if (req_q.adr == AUTO_WRITE_OFFSET) begin
                        target_q    <= req_q.dat_w[6:0];
                        index_q     <= req_q.dat_w[15:8];
                        data_q      <= req_q.dat_w[23:16];
                        auto_active <= 1'b1;
                    end
                    start     <= 1'b1;
                    busy      <= 1'b1;
                    nack_flag <= 1'b0;
                    state     <= CU_XFER_WAIT;
                end
                CU_XFER_WAIT: begin
                    if (done) begin
                        ack_q       <= 1'b1;
                        busy        <= 1'b0;
                        nack_flag   <= nack;
                        auto_active <= 1'b0;
                        state       <= CU_IDLE;
                    end
                end
                default: state <= CU_IDLE;
            endcase
        end
    end

    assign wb_rsp.ack   = ack_q;
    assign wb_rsp.dat_r = dat_r_q;

    assign cmd.target = target_q;
    assign cmd.index  = index_q;
    assign cmd.data   = data_q;

    // AUTO_WRITE runs even with the CONTROL enable cleared
    assign tick_enable = enable_q | auto_active;
    assign prescale    = prescale_q;

endmodule

// ==== verilog/i2c_pkg.sv ====
// I2C write master shared definitions: register map, bus and pin structs, FSM states
package i2c_pkg;

    // Register byte offsets on the Wishbone port
    localparam logic [7:0] STATUS_OFFSET     = 8'h00;
    localparam logic [7:0] CONTROL_OFFSET    = 8'h04;
    localparam logic [7:0] REGISTER_OFFSET   = 8'h08;
    localparam logic [7:0] DATA_OFFSET       = 8'h0C;
    localparam logic [7:0] PRESCALE_OFFSET   = 8'h10;
    localparam logic [7:0] START_OFFSET      = 8'h14;
    localparam logic [7:0] AUTO_WRITE_OFFSET = 8'h18;

    localparam int ADDR_WIDTH = 8;
    localparam int DATA_WIDTH = 32;

    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [ADDR_WIDTH-1:0] adr;
        logic [DATA_WIDTH-1:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic                  ack;
        logic [DATA_WIDTH-1:0] dat_r;
    } wb_rsp_t;

    // Fields of one three-byte write
    typedef struct packed {
        logic [6:0] target;
        logic [7:0] index;
        logic [7:0] data;
    } i2c_cmd_t;

    // A bit at 1 pulls its line low
    typedef struct packed {
        logic scl_low;
        logic sda_low;
    } i2c_pins_t;

    typedef enum logic [1:0] {
        CU_IDLE,
        CU_REG_WRITE,
        CU_XFER_LAUNCH,
        CU_XFER_WAIT
    } cu_state_t;

    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_START_COND,
        ENG_SEND_BIT,
        ENG_ACK_BIT,
        ENG_STOP_COND
    } eng_state_t;

    // Quarter of a bit period
    typedef logic [1:0] quarter_t;

endpackage
